/* source/core_mem_pkg.sv */
`default_nettype none

package core_mem_pkg;

  // core side of the load/store port
  localparam int ADDR_W      = 32;
  localparam int CORE_DATA_W = 32;
  localparam int CORE_BE_W   = CORE_DATA_W / 8;

  // local data RAM geometry
  localparam int MEM_DATA_W     = 64;
  localparam int MEM_BE_W       = MEM_DATA_W / 8;
  localparam int DATA_RAM_BYTES = 4096;
  localparam int MEM_WORDS      = DATA_RAM_BYTES / MEM_BE_W;
  localparam int MEM_IDX_W      = $clog2(MEM_WORDS);

  // region decode on the upper address bits
  localparam int TAG_W = 12;
  localparam logic [TAG_W-1:0] LOCAL_TAG = 12'h001;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [CORE_DATA_W-1:0] core_data_t;
  typedef logic [CORE_BE_W-1:0]   core_be_t;
  typedef logic [MEM_DATA_W-1:0]  mem_data_t;
  typedef logic [MEM_BE_W-1:0]    mem_be_t;
  typedef logic [MEM_IDX_W-1:0]   mem_idx_t;
  typedef logic [TAG_W-1:0]       region_tag_t;

  // where the next core response comes from
  typedef enum logic [0:0] {
    SRC_RAM = 1'b0,
    SRC_EXT = 1'b1
  } resp_src_e;

endpackage

`default_nettype wire

/* source/data_sp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sp_ram (
  input  wire logic                    clk,
  input  wire logic                    en_i,
  input  wire logic                    we_i,
  input  wire core_mem_pkg::mem_idx_t  idx_i,
  input  wire core_mem_pkg::mem_be_t   be_i,
  input  wire core_mem_pkg::mem_data_t wdata_i,
  output core_mem_pkg::mem_data_t      rdata_o
);

  import core_mem_pkg::*;

  mem_data_t mem [MEM_WORDS];

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int i = 0; i < MEM_BE_W; i++) begin
        if (be_i[i]) begin
          mem[idx_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // read on every enabled cycle returns old data on a write
  always_ff @(posedge clk) begin
    if (en_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

`default_nettype wire

/* source/lsu_demux.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_demux (
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  input  wire logic                    core_req_i,
  input  wire core_mem_pkg::addr_t     core_addr_i,
  input  wire logic                    core_we_i,
  input  wire core_mem_pkg::core_be_t  core_be_i,
  input  wire core_mem_pkg::core_data_t core_wdata_i,
  output logic                         core_gnt_o,
  output logic                         core_rvalid_o,
  output core_mem_pkg::core_data_t     core_rdata_o,

  output logic                         loc_req_o,
  output core_mem_pkg::addr_t          loc_addr_o,
  output logic                         loc_we_o,
  output core_mem_pkg::core_be_t       loc_be_o,
  output core_mem_pkg::core_data_t     loc_wdata_o,
  input  wire logic                    loc_gnt_i,
  input  wire logic                    loc_rvalid_i,
  input  wire core_mem_pkg::core_data_t loc_rdata_i,

  output logic                         ext_req_o,
  output core_mem_pkg::addr_t          ext_addr_o,
  output logic                         ext_we_o,
  output core_mem_pkg::core_be_t       ext_be_o,
  output core_mem_pkg::core_data_t     ext_wdata_o,
  input  wire logic                    ext_gnt_i,
  input  wire logic                    ext_rvalid_i,
  input  wire core_mem_pkg::core_data_t ext_rdata_i
);

  import core_mem_pkg::*;

  region_tag_t req_tag;
  logic        is_ext;
  resp_src_e   resp_src_q;
  resp_src_e   resp_src_d;

  // anything outside the local tag goes to the external port
  assign req_tag = core_addr_i[ADDR_W-1 -: TAG_W];
  assign is_ext  = (req_tag != LOCAL_TAG);

  assign loc_req_o   = core_req_i & ~is_ext;
  assign loc_addr_o  = core_addr_i;
  assign loc_we_o    = core_we_i;
  assign loc_be_o    = core_be_i;
  assign loc_wdata_o = core_wdata_i;

  assign ext_req_o   = core_req_i & is_ext;
  assign ext_addr_o  = core_addr_i;
  assign ext_we_o    = core_we_i;
  assign ext_be_o    = core_be_i;
  assign ext_wdata_o = core_wdata_i;

  // grant comes from the addressed target and the source follows the request
  always_comb begin
    resp_src_d = resp_src_q;
    core_gnt_o = 1'b0;
    if (ext_req_o) begin
      core_gnt_o = ext_gnt_i;
      resp_src_d = SRC_EXT;
    end else if (loc_req_o) begin
      core_gnt_o = loc_gnt_i;
      resp_src_d = SRC_RAM;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= SRC_RAM;
    end else begin
      resp_src_q <= resp_src_d;
    end
  end

  // only one target can have a response in flight
  assign core_rvalid_o = loc_rvalid_i | ext_rvalid_i;
  assign core_rdata_o  = (resp_src_q == SRC_EXT) ? ext_rdata_i : loc_rdata_i;

endmodule

`default_nettype wire

/* source/ram_port_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_port_mux (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // wide host port without a grant
  input  wire logic                     host_req_i,
  input  wire logic                     host_we_i,
  input  wire core_mem_pkg::mem_idx_t   host_idx_i,
  input  wire core_mem_pkg::mem_be_t    host_be_i,
  input  wire core_mem_pkg::mem_data_t  host_wdata_i,
  output core_mem_pkg::mem_data_t       host_rdata_o,

  // 32-bit core port
  input  wire logic                     loc_req_i,
  input  wire logic                     loc_we_i,
  input  wire core_mem_pkg::addr_t      loc_addr_i,
  input  wire core_mem_pkg::core_be_t   loc_be_i,
  input  wire core_mem_pkg::core_data_t loc_wdata_i,
  output logic                          loc_gnt_o,
  output logic                          loc_rvalid_o,
  output core_mem_pkg::core_data_t      loc_rdata_o,

  // RAM side
  output logic                          ram_en_o,
  output logic                          ram_we_o,
  output core_mem_pkg::mem_idx_t        ram_idx_o,
  output core_mem_pkg::mem_be_t         ram_be_o,
  output core_mem_pkg::mem_data_t       ram_wdata_o,
  input  wire core_mem_pkg::mem_data_t  ram_rdata_i
);

  import core_mem_pkg::*;

  mem_idx_t  loc_idx;
  logic      loc_half;
  mem_be_t   loc_be_wide;
  mem_data_t loc_wdata_wide;
  logic      gnt_q;
  logic      half_q;

  // word index above the byte offset and bit 2 for the half
  assign loc_idx  = loc_addr_i[$clog2(MEM_BE_W) +: MEM_IDX_W];
  assign loc_half = loc_addr_i[$clog2(CORE_BE_W)];

  // fold the core access onto one half of the 64-bit word
  assign loc_be_wide    = loc_half ? {loc_be_i, {CORE_BE_W{1'b0}}}
                                   : {{CORE_BE_W{1'b0}}, loc_be_i};
  assign loc_wdata_wide = {loc_wdata_i, loc_wdata_i};

  // host has fixed priority
  assign loc_gnt_o = loc_req_i & ~host_req_i;

  always_comb begin
    ram_en_o    = host_req_i | loc_req_i;
    ram_we_o    = loc_we_i;
    ram_idx_o   = loc_idx;
    ram_be_o    = loc_be_wide;
    ram_wdata_o = loc_wdata_wide;
    if (host_req_i) begin
      ram_we_o    = host_we_i;
      ram_idx_o   = host_idx_i;
      ram_be_o    = host_be_i;
      ram_wdata_o = host_wdata_i;
    end
  end

  // core response follows the grant by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q  <= 1'b0;
      half_q <= 1'b0;
    end else begin
      gnt_q <= loc_gnt_o;
      if (loc_gnt_o) begin
        half_q <= loc_half;
      end
    end
  end

  assign loc_rvalid_o = gnt_q;
  assign loc_rdata_o  = half_q ? ram_rdata_i[MEM_DATA_W-1:CORE_DATA_W]
                               : ram_rdata_i[CORE_DATA_W-1:0];

  // RAM output already lags the host strobe by one cycle
  assign host_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

/* source/core_data_region.sv */
`timescale 1ns/1ps
`default_nettype none

module core_data_region (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // core load/store port
  input  wire logic                     core_req_i,
  input  wire core_mem_pkg::addr_t      core_addr_i,
  input  wire logic                     core_we_i,
  input  wire core_mem_pkg::core_be_t   core_be_i,
  input  wire core_mem_pkg::core_data_t core_wdata_i,
  output logic                          core_gnt_o,
  output logic                          core_rvalid_o,
  output core_mem_pkg::core_data_t      core_rdata_o,

  // external bus port
  output logic                          ext_req_o,
  output core_mem_pkg::addr_t           ext_addr_o,
  output logic                          ext_we_o,
  output core_mem_pkg::core_be_t        ext_be_o,
  output core_mem_pkg::core_data_t      ext_wdata_o,
  input  wire logic                     ext_gnt_i,
  input  wire logic                     ext_rvalid_i,
  input  wire core_mem_pkg::core_data_t ext_rdata_i,

  // wide host port into the data RAM
  input  wire logic                     host_req_i,
  input  wire logic                     host_we_i,
  input  wire core_mem_pkg::mem_idx_t   host_idx_i,
  input  wire core_mem_pkg::mem_be_t    host_be_i,
  input  wire core_mem_pkg::mem_data_t  host_wdata_i,
  output core_mem_pkg::mem_data_t       host_rdata_o
);

  import core_mem_pkg::*;

  // demux to RAM mux
  logic       loc_req;
  addr_t      loc_addr;
  logic       loc_we;
  core_be_t   loc_be;
  core_data_t loc_wdata;
  logic       loc_gnt;
  logic       loc_rvalid;
  core_data_t loc_rdata;

  // RAM mux to RAM
  logic      ram_en;
  logic      ram_we;
  mem_idx_t  ram_idx;
  mem_be_t   ram_be;
  mem_data_t ram_wdata;
  mem_data_t ram_rdata;

  lsu_demux u_lsu_demux (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_req_i    (core_req_i),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i),
    .core_gnt_o    (core_gnt_o),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .loc_req_o     (loc_req),
    .loc_addr_o    (loc_addr),
    .loc_we_o      (loc_we),
    .loc_be_o      (loc_be),
    .loc_wdata_o   (loc_wdata),
    .loc_gnt_i     (loc_gnt),
    .loc_rvalid_i  (loc_rvalid),
    .loc_rdata_i   (loc_rdata),
    .ext_req_o     (ext_req_o),
    .ext_addr_o    (ext_addr_o),
    .ext_we_o      (ext_we_o),
    .ext_be_o      (ext_be_o),
    .ext_wdata_o   (ext_wdata_o),
    .ext_gnt_i     (ext_gnt_i),
    .ext_rvalid_i  (ext_rvalid_i),
    .ext_rdata_i   (ext_rdata_i)
  );

  ram_port_mux u_ram_port_mux (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_idx_i   (host_idx_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o),
    .loc_req_i    (loc_req),
    .loc_we_i     (loc_we),
    .loc_addr_i   (loc_addr),
    .loc_be_i     (loc_be),
    .loc_wdata_i  (loc_wdata),
    .loc_gnt_o    (loc_gnt),
    .loc_rvalid_o (loc_rvalid),
    .loc_rdata_o  (loc_rdata),
    .ram_en_o     (ram_en),
    .ram_we_o     (ram_we),
    .ram_idx_o    (ram_idx),
    .ram_be_o     (ram_be),
    .ram_wdata_o  (ram_wdata),
    .ram_rdata_i  (ram_rdata)
  );

  data_sp_ram u_data_sp_ram (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 2;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset low for the first rising edges
  initial begin
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_core_data_region.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_data_region;

  import core_mem_pkg::*;

  localparam int unsigned RAND_SEED   = 52236;
  localparam int          RST_TIMEOUT = 10;
  localparam int          GNT_TIMEOUT = 20;
  localparam int          RSP_TIMEOUT = 20;
  localparam int          LOCAL_ITERS = 40;
  localparam int          ALT_ITERS   = 12;
  localparam core_data_t  EXT_XOR     = 32'hA5A5A5A5;

  logic       clk;
  logic       rst_n;
  logic       core_req_i;
  addr_t      core_addr_i;
  logic       core_we_i;
  core_be_t   core_be_i;
  core_data_t core_wdata_i;
  logic       core_gnt_o;
  logic       core_rvalid_o;
  core_data_t core_rdata_o;
  logic       ext_req_o;
  addr_t      ext_addr_o;
  logic       ext_we_o;
  core_be_t   ext_be_o;
  core_data_t ext_wdata_o;
  logic       ext_gnt_i;
  logic       ext_rvalid_i;
  core_data_t ext_rdata_i;
  logic       host_req_i;
  logic       host_we_i;
  mem_idx_t   host_idx_i;
  mem_be_t    host_be_i;
  mem_data_t  host_wdata_i;
  mem_data_t  host_rdata_o;

  // mirror of the RAM contents
  mem_data_t ref_mem [MEM_WORDS];
  int        check_errors;
  int        timeout_errors;
  int        ext_wait;
  logic      ext_seen;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  core_data_region dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_req_i    (core_req_i),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i),
    .core_gnt_o    (core_gnt_o),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .ext_req_o     (ext_req_o),
    .ext_addr_o    (ext_addr_o),
    .ext_we_o      (ext_we_o),
    .ext_be_o      (ext_be_o),
    .ext_wdata_o   (ext_wdata_o),
    .ext_gnt_i     (ext_gnt_i),
    .ext_rvalid_i  (ext_rvalid_i),
    .ext_rdata_i   (ext_rdata_i),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_idx_i    (host_idx_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rdata_o  (host_rdata_o)
  );

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      check_errors++;
    end
  endtask

  // start pattern built from the whole word index
  function automatic mem_data_t fill_word(input mem_idx_t idx);
    return {16'hC0DE, 7'h00, idx, 16'h5EED, 7'h7F, ~idx};
  endfunction

  // word index from bits 11..3 and the half from bit 2
  function automatic core_data_t expected_local(input addr_t addr);
    mem_data_t word;
    word = ref_mem[addr[11:3]];
    return addr[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic mirror_core_write(input addr_t addr, input core_be_t be, input core_data_t data);
    mem_idx_t idx;
    int       base;
    idx  = addr[11:3];
    base = addr[2] ? 32 : 0;
    for (int i = 0; i < CORE_BE_W; i++) begin
      if (be[i]) begin
        ref_mem[idx][base + 8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  // host write strobe held for a number of cycles
  task automatic host_write(input mem_idx_t idx, input mem_be_t be, input mem_data_t data,
                            input int cycles);
    @(posedge clk);
    host_req_i   <= 1'b1;
    host_we_i    <= 1'b1;
    host_idx_i   <= idx;
    host_be_i    <= be;
    host_wdata_i <= data;
    repeat (cycles) @(posedge clk);
    host_req_i <= 1'b0;
    host_we_i  <= 1'b0;
    for (int i = 0; i < MEM_BE_W; i++) begin
      if (be[i]) begin
        ref_mem[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic host_read_check(input string name, input mem_idx_t idx);
    @(posedge clk);
    host_req_i <= 1'b1;
    host_we_i  <= 1'b0;
    host_idx_i <= idx;
    @(posedge clk);
    host_req_i <= 1'b0;
    @(negedge clk);
    check_value(name, ref_mem[idx], host_rdata_o);
  endtask

  // one core request that returns the data and the grant and response delays
  task automatic core_access(input string name, input addr_t addr, input logic we,
                             input core_be_t be, input core_data_t wdata,
                             output core_data_t rdata, output int gnt_wait, output int rsp_lat);
    int   n;
    logic to_ext;
    to_ext = (addr[ADDR_W-1 -: TAG_W] != LOCAL_TAG);
    @(posedge clk);
    core_req_i   <= 1'b1;
    core_addr_i  <= addr;
    core_we_i    <= we;
    core_be_i    <= be;
    core_wdata_i <= wdata;
    @(negedge clk);
    check_value({name, " ext_req"}, 64'(to_ext), 64'(ext_req_o));
    if (to_ext) begin
      check_value({name, " ext_addr"}, 64'(addr), 64'(ext_addr_o));
      check_value({name, " ext_we"}, 64'(we), 64'(ext_we_o));
      check_value({name, " ext_be"}, 64'(be), 64'(ext_be_o));
      check_value({name, " ext_wdata"}, 64'(wdata), 64'(ext_wdata_o));
    end
    n = 0;
    while (!core_gnt_o && n < GNT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (core_gnt_o) else begin
      $display("timeout: %s was never granted", name);
      timeout_errors++;
    end
    gnt_wait = n;
    @(posedge clk);
    core_req_i <= 1'b0;
    @(negedge clk);
    n = 1;
    while (!core_rvalid_o && n < RSP_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (core_rvalid_o) else begin
      $display("timeout: no response pulse for %s", name);
      timeout_errors++;
    end
    rsp_lat = n;
    rdata   = core_rdata_o;
    @(negedge clk);
    assert (!core_rvalid_o) else begin
      $display("response pulse for %s lasted more than one cycle", name);
      check_errors++;
    end
  endtask

  // external slave grants after 0..3 cycles and answers one cycle after the grant
  initial begin
    ext_gnt_i    <= 1'b0;
    ext_rvalid_i <= 1'b0;
    ext_rdata_i  <= '0;
    ext_seen     = 1'b0;
    ext_wait     = 0;
    forever begin
      @(posedge clk);
      ext_rvalid_i <= 1'b0;
      if (!rst_n) begin
        ext_gnt_i <= 1'b0;
        ext_seen  = 1'b0;
      end else if (ext_req_o && ext_gnt_i) begin
        ext_gnt_i    <= 1'b0;
        ext_rvalid_i <= 1'b1;
        ext_rdata_i  <= ext_addr_o ^ EXT_XOR;
        ext_seen     = 1'b0;
      end else if (ext_req_o) begin
        if (!ext_seen) begin
          ext_seen = 1'b1;
          ext_wait = $urandom_range(3, 0);
        end
        if (ext_wait == 0) begin
          ext_gnt_i <= 1'b1;
        end else begin
          ext_wait--;
        end
      end
    end
  end

  initial begin
    core_data_t rdata;
    core_data_t wdata;
    core_be_t   be;
    addr_t      addr;
    mem_data_t  wide;
    mem_idx_t   idx;
    logic       we;
    logic [31:0] rnd;
    int         gnt_wait;
    int         rsp_lat;
    int         n;
    check_errors   = 0;
    timeout_errors = 0;
    void'($urandom(RAND_SEED));
    core_req_i   <= 1'b0;
    core_addr_i  <= '0;
    core_we_i    <= 1'b0;
    core_be_i    <= '0;
    core_wdata_i <= '0;
    host_req_i   <= 1'b0;
    host_we_i    <= 1'b0;
    host_idx_i   <= '0;
    host_be_i    <= '0;
    host_wdata_i <= '0;
    n = 0;
    while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (rst_n === 1'b1) else begin
      $display("timeout: reset was never released");
      timeout_errors++;
    end

    // idle outputs after reset
    repeat (3) begin
      @(negedge clk);
      check_value("idle core_gnt", 64'd0, 64'(core_gnt_o));
      check_value("idle core_rvalid", 64'd0, 64'(core_rvalid_o));
      check_value("idle ext_req", 64'd0, 64'(ext_req_o));
    end

    for (int i = 0; i < MEM_WORDS; i++) begin
      host_write(mem_idx_t'(i), 8'hFF, fill_word(mem_idx_t'(i)), 1);
    end

    // local writes followed by reads through an aliased address
    for (int i = 0; i < LOCAL_ITERS; i++) begin
      rnd   = $urandom();
      addr  = {LOCAL_TAG, rnd[19:2], 2'b00};
      be    = core_be_t'($urandom_range(15, 0));
      wdata = $urandom();
      core_access("local write", addr, 1'b1, be, wdata, rdata, gnt_wait, rsp_lat);
      mirror_core_write(addr, be, wdata);
      check_value("local write grant wait", 64'd0, 64'(gnt_wait));
      check_value("local write latency", 64'd1, 64'(rsp_lat));
      rnd  = $urandom();
      addr = {LOCAL_TAG, rnd[7:0], addr[11:0]};
      core_access("local read", addr, 1'b0, 4'hF, 32'h0, rdata, gnt_wait, rsp_lat);
      check_value("local read data", 64'(expected_local(addr)), 64'(rdata));
      check_value("local read grant wait", 64'd0, 64'(gnt_wait));
      check_value("local read latency", 64'd1, 64'(rsp_lat));
    end

    // host words read back as two core halves and core writes read back by the host
    for (int i = 0; i < 8; i++) begin
      idx  = mem_idx_t'($urandom());
      wide = {$urandom(), $urandom()};
      host_write(idx, 8'hFF, wide, 1);
      for (int h = 0; h < 2; h++) begin
        rnd  = $urandom();
        addr = {LOCAL_TAG, rnd[7:0], idx, h[0], 2'b00};
        core_access("host to core read", addr, 1'b0, 4'hF, 32'h0, rdata, gnt_wait, rsp_lat);
        check_value("host to core half", 64'((h != 0) ? wide[63:32] : wide[31:0]), 64'(rdata));
      end
      rnd   = $urandom();
      addr  = {LOCAL_TAG, rnd[19:2], 2'b00};
      be    = core_be_t'($urandom_range(15, 0));
      wdata = $urandom();
      core_access("core to host write", addr, 1'b1, be, wdata, rdata, gnt_wait, rsp_lat);
      mirror_core_write(addr, be, wdata);
      host_read_check("core to host read", addr[11:3]);
    end

    // host strobe on the same word holds off the core for three cycles
    for (int i = 0; i < 6; i++) begin
      rnd   = $urandom();
      addr  = {LOCAL_TAG, rnd[19:2], 2'b00};
      wide  = {$urandom(), $urandom()};
      be    = core_be_t'($urandom_range(15, 0));
      wdata = $urandom();
      we    = i[0];
      fork
        host_write(addr[11:3], 8'hFF, wide, 3);
        core_access("host conflict", addr, we, be, wdata, rdata, gnt_wait, rsp_lat);
      join
      check_value("conflict grant wait", 64'd3, 64'(gnt_wait));
      check_value("conflict latency", 64'd1, 64'(rsp_lat));
      if (we) begin
        mirror_core_write(addr, be, wdata);
        core_access("conflict readback", addr, 1'b0, 4'hF, 32'h0, rdata, gnt_wait, rsp_lat);
      end
      check_value("conflict data", 64'(expected_local(addr)), 64'(rdata));
    end

    // external requests followed by local and external reads in turn
    for (int i = 0; i < 10; i++) begin
      rnd   = $urandom();
      addr  = {1'b1, rnd[30:2], 2'b00};
      we    = 1'($urandom_range(1, 0));
      be    = core_be_t'($urandom_range(15, 0));
      wdata = $urandom();
      core_access("ext access", addr, we, be, wdata, rdata, gnt_wait, rsp_lat);
      if (!we) begin
        check_value("ext read data", 64'(addr ^ EXT_XOR), 64'(rdata));
      end
    end
    for (int i = 0; i < ALT_ITERS; i++) begin
      rnd = $urandom();
      if (i[0] == 1'b0) begin
        addr = {LOCAL_TAG, rnd[19:2], 2'b00};
        core_access("alt local read", addr, 1'b0, 4'hF, 32'h0, rdata, gnt_wait, rsp_lat);
        check_value("alt local data", 64'(expected_local(addr)), 64'(rdata));
      end else begin
        addr = {1'b1, rnd[30:2], 2'b00};
        core_access("alt ext read", addr, 1'b0, 4'hF, 32'h0, rdata, gnt_wait, rsp_lat);
        check_value("alt ext data", 64'(addr ^ EXT_XOR), 64'(rdata));
      end
    end

    $display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/core_mem_pkg.sv
source/data_sp_ram.sv
source/lsu_demux.sv
source/ram_port_mux.sv
source/core_data_region.sv
testbench/tb_clock_gen.sv
testbench/tb_core_data_region.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_core_data_region
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" -Mdir "$OBJ" -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi

echo "PASS"
exit 0
